//--- design/codec_cfg_pkg.sv
// Shared types, init table and serial timing constants
// for the codec configuration block
package codec_cfg_pkg;

    typedef logic [4:0] reg_addr_t;              // Codec register address
    typedef logic [7:0] reg_data_t;              // Codec register value
    typedef logic [3:0] tx_gain_t;               // TX gain code
    typedef logic [4:0] rx_gain_t;               // RX gain code

    typedef enum logic [1:0] {
        OP_TX_GAIN,                              // Gain goes to data[3:0]
        OP_RX_GAIN,                              // Gain goes to data[4:0]
        OP_REG_WRITE,
        OP_REG_READ
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e   op;
        reg_addr_t addr;                         // Ignored by gain ops
        reg_data_t data;
    } host_cmd_t;

    // Shift order from the MSB, as seen on sdio
    typedef struct packed {
        logic      rd;                           // 1 for a read frame
        logic [1:0] pad;                         // Byte count field, always zero
        reg_addr_t addr;
        reg_data_t data;
    } spi_frame_t;

    typedef struct packed {
        logic      en;                           // Write this entry at init
        reg_data_t value;
    } init_entry_t;

    localparam int INIT_LEN = 20;

    // Entry n targets register n
    localparam init_entry_t [0:INIT_LEN-1] INIT_TABLE = {
        {1'b0, 8'h80}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00},    // 0x00..0x03
        {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00},                   // 0x04..0x06
        {1'b1, 8'h20},                           // 0x07 DC offset cal, RX filter off
        {1'b0, 8'h4b},                           // 0x08 RX filter corner
        {1'b0, 8'h00}, {1'b0, 8'h00},            // 0x09, 0x0a set by gain commands
        {1'b1, 8'h20},                           // 0x0b RX gain on PGA only
        {1'b1, 8'h43},                           // 0x0c TX twos complement, interpolation
        {1'b1, 8'h03},                           // 0x0d RX twos complement
        {1'b1, 8'h81},                           // 0x0e IAMP disabled
        {1'b0, 8'h00},                           // 0x0f
        {1'b1, 8'h80}, {1'b1, 8'h00},            // 0x10, 0x11 TX gain select
        {1'b1, 8'h00}, {1'b0, 8'h00}             // 0x12, 0x13
    };

    localparam reg_addr_t TX_GAIN_REG    = 5'h0a;
    localparam reg_addr_t RX_GAIN_REG    = 5'h09;
    localparam logic [3:0] TX_GAIN_PREFIX = 4'b0100;   // Above the 4-bit TX code
    localparam logic [2:0] RX_GAIN_PREFIX = 3'b010;    // Above the 5-bit RX code

    localparam int SCLK_HALF  = 2;               // Clocks per sclk half period
    localparam int SPI_BITS   = 16;              // Bits per frame
    localparam int HALF_CNT_W = $clog2(SCLK_HALF);
    localparam int BIT_CNT_W  = $clog2(SPI_BITS);

endpackage

//--- design/codec_host_port.sv
// Host req/ack slave with TX and RX gain shadows,
// turns host commands into serial frames
`timescale 1ns/100ps

module codec_host_port import codec_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       host_req_i,
    input  host_cmd_t  host_cmd_i,
    output logic       host_ack_o,
    output reg_data_t  host_rdata_o,
    output logic       frame_req_o,
    output spi_frame_t frame_o,
    input  logic       frame_ack_i,
    input  reg_data_t  frame_rdata_i
);

    typedef enum logic [1:0] {IDLE, SEND, WAIT_DROP, DONE} state_e;

    state_e     state;
    cmd_op_e    op_q;                            // Op of the frame in flight
    tx_gain_t   tx_gain;                         // Last TX gain sent to the codec
    rx_gain_t   rx_gain;                         // Last RX gain sent to the codec
    tx_gain_t   cmd_tx_gain;
    rx_gain_t   cmd_rx_gain;
    logic       gain_same;                       // Gain command repeats the shadow
    spi_frame_t cmd_frame;                       // Frame built from the command

    assign cmd_tx_gain = host_cmd_i.data[3:0];
    assign cmd_rx_gain = host_cmd_i.data[4:0];

    // Command decode
    always_comb begin
        gain_same = 1'b0;
        cmd_frame = '0;
        case (host_cmd_i.op)
            OP_TX_GAIN: begin
                gain_same      = (cmd_tx_gain == tx_gain);
                cmd_frame.addr = TX_GAIN_REG;
                cmd_frame.data = {TX_GAIN_PREFIX, cmd_tx_gain};
            end
            OP_RX_GAIN: begin
                gain_same      = (cmd_rx_gain == rx_gain);
                cmd_frame.addr = RX_GAIN_REG;
                cmd_frame.data = {RX_GAIN_PREFIX, cmd_rx_gain};
            end
            OP_REG_WRITE: begin
                cmd_frame.addr = host_cmd_i.addr;
                cmd_frame.data = host_cmd_i.data;
            end
            default: begin                       // OP_REG_READ
                cmd_frame.rd   = 1'b1;
                cmd_frame.addr = host_cmd_i.addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            host_ack_o  <= 1'b0;
            frame_req_o <= 1'b0;
            tx_gain     <= '0;
            rx_gain     <= '0;
        end else begin
            case (state)
                IDLE: if (host_req_i) begin
                    if (gain_same) begin         // Nothing to send, ack next cycle
                        host_ack_o <= 1'b1;
                        state      <= DONE;
                    end else begin
                        frame_req_o <= 1'b1;
                        state       <= SEND;
                    end
                end
                SEND: if (frame_ack_i) begin
                    frame_req_o <= 1'b0;
                    if (op_q == OP_TX_GAIN) tx_gain <= frame_o.data[3:0];
                    if (op_q == OP_RX_GAIN) rx_gain <= frame_o.data[4:0];
                    state <= WAIT_DROP;
                end
                WAIT_DROP: if (!frame_ack_i) begin   // Downstream back to idle
                    host_ack_o <= 1'b1;
                    state      <= DONE;
                end
                DONE: if (!host_req_i) begin
                    host_ack_o <= 1'b0;
                    state      <= IDLE;
                end
            endcase
        end
    end

    // Frame and read data holding
    always_ff @(posedge clk) begin
        if (state == IDLE && host_req_i) begin
            frame_o <= cmd_frame;
            op_q    <= host_cmd_i.op;
        end
        if (state == SEND && frame_ack_i) host_rdata_o <= frame_rdata_i;
    end

    // Ack only while req is up or in the cycle after it drops
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        host_ack_o |-> (host_req_i || $past(host_req_i)));

endmodule

//--- design/codec_frame_sched.sv
// Init table walker, then pass-through of host frames to the serial engine
`timescale 1ns/100ps

module codec_frame_sched import codec_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       host_req_i,
    input  spi_frame_t host_frame_i,
    output logic       host_ack_o,
    output reg_data_t  host_rdata_o,
    output logic       spi_req_o,
    output spi_frame_t spi_frame_o,
    input  logic       spi_ack_i,
    input  reg_data_t  spi_rdata_i,
    output logic       init_done_o
);

    typedef enum logic [1:0] {CHECK, SEND, WAIT_DROP, PASS} state_e;

    state_e      state;
    reg_addr_t   idx;                            // Table index, also the target register
    logic        init_req;                       // Req for table frames
    init_entry_t entry;
    logic        last_entry;
    spi_frame_t  init_frame;

    assign entry      = INIT_TABLE[idx];
    assign last_entry = (idx == reg_addr_t'(INIT_LEN - 1));

    always_comb begin
        init_frame      = '0;                    // Write frame, rd and pad zero
        init_frame.addr = idx;
        init_frame.data = entry.value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= CHECK;
            idx         <= '0;
            init_req    <= 1'b0;
            init_done_o <= 1'b0;
        end else begin
            case (state)
                CHECK: begin
                    if (entry.en) begin
                        init_req <= 1'b1;
                        state    <= SEND;
                    end else if (last_entry) begin   // Disabled entry skipped in one cycle
                        init_done_o <= 1'b1;
                        state       <= PASS;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                SEND: if (spi_ack_i) begin
                    init_req <= 1'b0;
                    state    <= WAIT_DROP;
                end
                WAIT_DROP: if (!spi_ack_i) begin
                    if (last_entry) begin
                        init_done_o <= 1'b1;
                        state       <= PASS;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= CHECK;
                    end
                end
                PASS: state <= PASS;             // Table done, host owns the engine
            endcase
        end
    end

    // Host handshake mirrored once init is complete
    assign spi_req_o    = init_done_o ? host_req_i : init_req;
    assign spi_frame_o  = init_done_o ? host_frame_i : init_frame;
    assign host_ack_o   = init_done_o & spi_ack_i;   // Host held off during init
    assign host_rdata_o = spi_rdata_i;

endmodule

//--- design/codec_spi_master.sv
// 16-bit serial shifter for the codec 4-wire port
// Drives sclk, sdio and sen_n, captures sdo
`timescale 1ns/100ps

module codec_spi_master import codec_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    input  spi_frame_t frame_i,
    output logic       ack_o,
    output reg_data_t  rdata_o,
    output logic       sclk_o,
    output logic       sdio_o,
    input  logic       sdo_i,
    output logic       sen_n_o
);

    typedef enum logic [1:0] {IDLE, LOW, HIGH, ACK} state_e;

    state_e                state;
    logic [SPI_BITS-1:0]   shreg;                // Out on the MSB, sdo in at the LSB
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [HALF_CNT_W-1:0] half_cnt;             // Clocks into the current half period
    logic                  half_end;
    logic                  last_bit;

    assign half_end = (half_cnt == HALF_CNT_W'(SCLK_HALF - 1));
    assign last_bit = (bit_cnt == BIT_CNT_W'(SPI_BITS - 1));
    assign sdio_o   = shreg[SPI_BITS-1] & ~sen_n_o;
    assign rdata_o  = shreg[7:0];                // Data phase bits from sdo

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            sen_n_o  <= 1'b1;
            sclk_o   <= 1'b0;
            ack_o    <= 1'b0;
            bit_cnt  <= '0;
            half_cnt <= '0;
        end else begin
            case (state)
                IDLE: if (req_i) begin
                    sen_n_o  <= 1'b0;            // Select on the cycle after req
                    bit_cnt  <= '0;
                    half_cnt <= '0;
                    state    <= LOW;
                end
                LOW: begin
                    if (half_end) begin          // Codec samples sdio on this rise
                        sclk_o   <= 1'b1;
                        half_cnt <= '0;
                        state    <= HIGH;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                HIGH: begin
                    if (half_end) begin
                        sclk_o   <= 1'b0;
                        half_cnt <= '0;
                        if (last_bit) begin      // Deselect and ack together
                            sen_n_o <= 1'b1;
                            ack_o   <= 1'b1;
                            state   <= ACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= LOW;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                ACK: if (!req_i) begin
                    ack_o <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    // Load on req, shift on each falling sclk
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            shreg <= frame_i;
        end else if (state == HIGH && half_end) begin
            shreg <= {shreg[SPI_BITS-2:0], sdo_i};
        end
    end

    // Clock parked low outside a frame
    sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
        sen_n_o |-> !sclk_o);

endmodule

//--- design/codec_cfg_top.sv
// Codec configuration top: host port, frame scheduler and serial engine
`timescale 1ns/100ps

module codec_cfg_top import codec_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      host_req_i,
    input  host_cmd_t host_cmd_i,
    output logic      host_ack_o,
    output reg_data_t host_rdata_o,
    output logic      init_done_o,
    output logic      sclk_o,
    output logic      sdio_o,
    input  logic      sdo_i,
    output logic      sen_n_o
);

    logic       hf_req;                          // Host port to scheduler
    spi_frame_t hf_frame;
    logic       hf_ack;
    reg_data_t  hf_rdata;
    logic       sf_req;                          // Scheduler to serial engine
    spi_frame_t sf_frame;
    logic       sf_ack;
    reg_data_t  sf_rdata;

    codec_host_port u_host_port (
        .clk           (clk),
        .rst           (rst),
        .host_req_i    (host_req_i),
        .host_cmd_i    (host_cmd_i),
        .host_ack_o    (host_ack_o),
        .host_rdata_o  (host_rdata_o),
        .frame_req_o   (hf_req),
        .frame_o       (hf_frame),
        .frame_ack_i   (hf_ack),
        .frame_rdata_i (hf_rdata)
    );

    codec_frame_sched u_frame_sched (
        .clk          (clk),
        .rst          (rst),
        .host_req_i   (hf_req),
        .host_frame_i (hf_frame),
        .host_ack_o   (hf_ack),
        .host_rdata_o (hf_rdata),
        .spi_req_o    (sf_req),
        .spi_frame_o  (sf_frame),
        .spi_ack_i    (sf_ack),
        .spi_rdata_i  (sf_rdata),
        .init_done_o  (init_done_o)
    );

    codec_spi_master u_spi_master (
        .clk     (clk),
        .rst     (rst),
        .req_i   (sf_req),
        .frame_i (sf_frame),
        .ack_o   (sf_ack),
        .rdata_o (sf_rdata),
        .sclk_o  (sclk_o),
        .sdio_o  (sdio_o),
        .sdo_i   (sdo_i),
        .sen_n_o (sen_n_o)
    );

endmodule

//--- testbench/codec_spi_model.sv
// Behavioral codec serial port slave
// 32-entry register file, writes on sen_n rise, read data on sdo
`timescale 1ns/100ps

module codec_spi_model import codec_cfg_pkg::*; (
    input  logic sclk_i,
    input  logic sdio_i,
    output logic sdo_o,
    input  logic sen_n_i
);

    reg_data_t  mem [0:31] = '{default: '0};     // Codec register file
    spi_frame_t sh = '0;                         // First bit ends up at the MSB
    int         cnt = 0;                         // Rising sclk edges seen in this frame
    logic       rd_q = 1'b0;                     // Read flag of the current frame
    reg_addr_t  addr_q = '0;
    logic       sdo_q = 1'b0;

    assign sdo_o = sdo_q;

    always @(posedge sclk_i or posedge sen_n_i) begin
        if (sen_n_i) begin
            // A full write frame updates the register when the codec is deselected
            if (cnt == SPI_BITS && !sh.rd) begin
                mem[sh.addr] <= sh.data;
            end
            cnt   <= 0;
            sdo_q <= 1'b0;
        end else begin
            sh  <= {sh[SPI_BITS-2:0], sdio_i};   // Sampled on rising sclk
            cnt <= cnt + 1;
            if (cnt == 0) begin
                rd_q <= sdio_i;
            end
            if (cnt == 7) begin
                addr_q <= {sh[3:0], sdio_i};     // Last address bit arrives now
            end
            if (cnt >= 8) begin                  // Data phase, MSB first
                sdo_q <= rd_q ? mem[addr_q][3'(SPI_BITS - 1 - cnt)] : 1'b0;
            end
        end
    end

endmodule

//--- testbench/codec_cfg_tb.sv
// Testbench for the codec configuration block
// Clock, reset, random host commands, reference register image and compare tasks
`timescale 1ns/100ps

module codec_cfg_tb import codec_cfg_pkg::*; ();

    localparam int CMD_TIMEOUT  = 200;           // Cycles for one host command
    localparam int INIT_TIMEOUT = 3000;          // Whole init table plus one command
    localparam int NUM_GAINS    = 24;
    localparam int NUM_WRITES   = 200;

    logic      clk = 1'b0;
    logic      rst;
    logic      host_req;
    host_cmd_t host_cmd;
    logic      host_ack;
    reg_data_t host_rdata;
    logic      init_done;
    logic      sclk;
    logic      sdio;
    logic      sdo;
    logic      sen_n;

    reg_data_t image [0:31];                     // Expected codec register file
    tx_gain_t  tx_shadow;
    rx_gain_t  rx_shadow;
    int        seed = 32'h705b5e88;

    codec_cfg_top UUT (
        .clk          (clk),
        .rst          (rst),
        .host_req_i   (host_req),
        .host_cmd_i   (host_cmd),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .init_done_o  (init_done),
        .sclk_o       (sclk),
        .sdio_o       (sdio),
        .sdo_i        (sdo),
        .sen_n_o      (sen_n)
    );

    codec_spi_model codec (
        .sclk_i  (sclk),
        .sdio_i  (sdio),
        .sdo_o   (sdo),
        .sen_n_i (sen_n)
    );

    always #20 clk = ~clk;                       // 40 ns period

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            stop_with_fail($sformatf(
                "ERROR at %0t ns: read of register 0x%02h returned 0x%02h, expected 0x%02h",
                $time, addr, got, exp));
        end
    endtask

    task automatic check_mem(input reg_addr_t addr, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            stop_with_fail($sformatf(
                "ERROR at %0t ns: codec register 0x%02h holds 0x%02h, expected 0x%02h",
                $time, addr, got, exp));
        end
    endtask

    task automatic check_all_regs();
        reg_addr_t ra;
        for (int a = 0; a < 32; a++) begin
            ra = reg_addr_t'(a);
            check_mem(ra, codec.mem[ra], image[ra]);
        end
    endtask

    // Full four-phase exchange entered and left 2 ns after a rising edge
    task automatic run_cmd(input host_cmd_t cmd, input bit quiet, input int limit,
                           output reg_data_t rdata);
        int cnt;
        cnt      = 0;
        host_cmd = cmd;
        host_req = 1'b1;
        while (!host_ack) begin
            @(posedge clk);
            #2;
            if (quiet && !sen_n) begin
                stop_with_fail(
                    "Serial port was selected for a gain command that repeats the current gain");
            end
            if (host_ack && !init_done) begin
                stop_with_fail(
                    "Host command was acknowledged before the init table was finished");
            end
            cnt++;
            if (cnt > limit) begin
                stop_with_fail("Timeout while waiting for the host acknowledge to rise");
            end
        end
        rdata    = host_rdata;                   // Valid while ack is high
        host_req = 1'b0;
        cnt      = 0;
        while (host_ack) begin
            @(posedge clk);
            #2;
            cnt++;
            if (cnt > limit) begin
                stop_with_fail("Timeout while waiting for the host acknowledge to fall");
            end
        end
    endtask

    // Gain command checked against the shadow model
    task automatic gain_cmd(input cmd_op_e op, input reg_data_t gain);
        host_cmd_t cmd;
        reg_data_t rdata;
        reg_addr_t gaddr;
        reg_data_t gval;
        logic      same;
        cmd      = '0;
        cmd.op   = op;
        cmd.data = gain;                         // Gain in the low bits
        if (op == OP_TX_GAIN) begin
            same  = (tx_gain_t'(gain) == tx_shadow);
            gaddr = TX_GAIN_REG;
            gval  = {TX_GAIN_PREFIX, tx_gain_t'(gain)};
        end else begin
            same  = (rx_gain_t'(gain) == rx_shadow);
            gaddr = RX_GAIN_REG;
            gval  = {RX_GAIN_PREFIX, rx_gain_t'(gain)};
        end
        run_cmd(cmd, same, CMD_TIMEOUT, rdata);
        if (!same) begin
            image[gaddr] = gval;
            if (op == OP_TX_GAIN) begin
                tx_shadow = tx_gain_t'(gain);
            end else begin
                rx_shadow = rx_gain_t'(gain);
            end
        end
        check_mem(gaddr, codec.mem[gaddr], image[gaddr]);
    endtask

    initial begin
        host_cmd_t cmd;
        reg_data_t rdata;
        reg_addr_t ra;
        cmd_op_e   op;
        reg_data_t gain;
        rst       = 1'b1;
        host_req  = 1'b0;
        host_cmd  = '0;
        tx_shadow = '0;
        rx_shadow = '0;
        for (int a = 0; a < 32; a++) begin
            image[reg_addr_t'(a)] = '0;          // Untouched registers stay zero
        end
        for (int i = 0; i < INIT_LEN; i++) begin
            ra = reg_addr_t'(i);
            if (INIT_TABLE[ra].en) begin
                image[ra] = INIT_TABLE[ra].value;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Read raised while the table is still being written
        repeat (10) @(posedge clk);
        #2;
        if (init_done) begin
            stop_with_fail("init_done_o was already high when the host request was raised");
        end
        cmd      = '0;
        cmd.op   = OP_REG_READ;
        cmd.addr = 5'h0e;
        run_cmd(cmd, 1'b0, INIT_TIMEOUT, rdata);
        check_reg(cmd.addr, rdata, image[cmd.addr]);
        check_all_regs();

        // Random gains, then exact repeats of both shadows
        for (int n = 0; n < NUM_GAINS; n++) begin
            op   = ($random(seed) & 1) ? OP_TX_GAIN : OP_RX_GAIN;
            gain = reg_data_t'(rx_gain_t'($random(seed)));
            if (op == OP_TX_GAIN) begin
                gain = reg_data_t'(tx_gain_t'(gain));
            end
            gain_cmd(op, gain);
        end
        gain_cmd(OP_TX_GAIN, reg_data_t'(tx_shadow));
        gain_cmd(OP_RX_GAIN, reg_data_t'(rx_shadow));

        for (int n = 0; n < NUM_WRITES; n++) begin
            cmd      = '0;
            cmd.op   = OP_REG_WRITE;
            cmd.addr = reg_addr_t'($random(seed));
            cmd.data = reg_data_t'($random(seed));
            image[cmd.addr] = cmd.data;          // Gain shadows untouched by raw writes
            run_cmd(cmd, 1'b0, CMD_TIMEOUT, rdata);
        end
        for (int a = 0; a < 32; a++) begin
            cmd      = '0;
            cmd.op   = OP_REG_READ;
            cmd.addr = reg_addr_t'(a);
            run_cmd(cmd, 1'b0, CMD_TIMEOUT, rdata);
            check_reg(cmd.addr, rdata, image[cmd.addr]);
        end
        check_all_regs();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- flist.f
design/codec_cfg_pkg.sv
design/codec_host_port.sv
design/codec_frame_sched.sv
design/codec_spi_master.sv
design/codec_cfg_top.sv
testbench/codec_spi_model.sv
testbench/codec_cfg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the codec configuration testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module codec_cfg_tb -f flist.f -o codec_cfg_sim &&
./obj_dir/codec_cfg_sim || {
    echo "Verilator build or simulation returned an error"
    exit 1
}
